// File: design/dac_channel.sv
// ******************************
// channel source select
// dma, ramp, pattern or zero
// ******************************

`timescale 1ns/1ps

module dac_channel (
  input  logic               dac_div_clk,
  input  logic               reset,
  input  logic               run,
  input  dac_pkg::src_sel_t  source,
  input  dac_pkg::sample_t   incr,
  input  dac_pkg::sample_t   pattern,
  input  dac_pkg::dma_word_t dma_data,
  output dac_pkg::dma_word_t samples
);

  import dac_pkg::*;

  dma_word_t ramp_data;
  dma_word_t sel_data;

  dac_ramp_gen i_ramp_gen (
    .dac_div_clk (dac_div_clk),
    .reset       (reset),
    .run         (run),
    .incr        (incr),
    .ramp_data   (ramp_data)
  );

  always_comb begin
    case (source)
      SRC_DMA:     sel_data = dma_data;
      SRC_RAMP:    sel_data = ramp_data;
      SRC_PATTERN: sel_data = {SAMPLES_PER_CYCLE{pattern}};
      SRC_ZERO:    sel_data = '0;
    endcase
  end

  // one pipeline stage that passes nothing while stopped
  always_ff @(posedge dac_div_clk) begin
    if (reset) begin
      samples <= '0;
    end else if (run) begin
      samples <= sel_data;
    end else begin
      samples <= '0;
    end
  end

endmodule

// File: design/dac_core.sv
// ******************************
// dac run control and dma requests
// with master/slave sync start
// ******************************

`timescale 1ns/1ps

module dac_core (
  input  logic               dac_div_clk,
  input  logic               reset,
  input  logic               ctrl_enable,
  input  logic               ctrl_sync_mode,
  input  dac_pkg::src_sel_t  ch0_source,
  input  dac_pkg::src_sel_t  ch1_source,
  input  dac_pkg::sample_t   ch0_incr,
  input  dac_pkg::sample_t   ch1_incr,
  input  dac_pkg::sample_t   ch0_pattern,
  input  dac_pkg::sample_t   ch1_pattern,
  input  logic               dac_sync_in,
  output logic               dac_sync_out,
  output logic               dac_valid_0,
  output logic               dac_valid_1,
  output logic               dac_enable_0,
  output logic               dac_enable_1,
  input  dac_pkg::dma_word_t dac_ddata_0,
  input  dac_pkg::dma_word_t dac_ddata_1,
  output logic               dac_running,
  output dac_pkg::dma_word_t samples_i,
  output dac_pkg::dma_word_t samples_q,
  output logic               samples_valid
);

  import dac_pkg::*;

  run_state_t state;
  run_state_t state_next;
  logic       enable_d;
  logic       enable_rise;
  logic       run;

  assign enable_rise = ctrl_enable & ~enable_d;

  // ******************************
  // run state machine
  // ******************************

  always_comb begin
    state_next = state;
    if (!ctrl_enable) begin
      state_next = ST_IDLE;
    end else begin
      case (state)
        ST_IDLE: begin
          if (enable_rise) begin
            state_next = ctrl_sync_mode ? ST_WAIT_SYNC : ST_RUN;
          end
        end
        ST_WAIT_SYNC: begin
          if (dac_sync_in) begin
            state_next = ST_RUN;
          end
        end
        ST_RUN:  state_next = ST_RUN;
        default: state_next = ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge dac_div_clk) begin
    if (reset) begin
      state         <= ST_IDLE;
      enable_d      <= 1'b0;
      samples_valid <= 1'b0;
    end else begin
      state         <= state_next;
      enable_d      <= ctrl_enable;
      // matches the channel output register
      samples_valid <= run;
    end
  end

  // same cycle as a non-sync master leaves idle, so slaves start with it
  assign dac_sync_out = enable_rise;

  assign dac_running  = (state == ST_RUN);
  assign run          = dac_running & ctrl_enable;

  // dma requests
  assign dac_valid_0  = run;
  assign dac_valid_1  = run;
  assign dac_enable_0 = ctrl_enable && (ch0_source == SRC_DMA);
  assign dac_enable_1 = ctrl_enable && (ch1_source == SRC_DMA);

  dac_channel i_channel_i (
    .dac_div_clk (dac_div_clk),
    .reset       (reset),
    .run         (run),
    .source      (ch0_source),
    .incr        (ch0_incr),
    .pattern     (ch0_pattern),
    .dma_data    (dac_ddata_0),
    .samples     (samples_i)
  );

  dac_channel i_channel_q (
    .dac_div_clk (dac_div_clk),
    .reset       (reset),
    .run         (run),
    .source      (ch1_source),
    .incr        (ch1_incr),
    .pattern     (ch1_pattern),
    .dma_data    (dac_ddata_1),
    .samples     (samples_q)
  );

  // no dma request without enable
  valid_needs_enable: assert property (
    @(posedge dac_div_clk) disable iff (reset)
    dac_valid_0 |-> ctrl_enable
  );

endmodule

// File: design/dac_output_if.sv
// ******************************
// dac output word formatting
// i/q interleave and frame marker
// ******************************

`timescale 1ns/1ps

module dac_output_if (
  input  logic               dac_div_clk,
  input  logic               reset,
  input  logic               ctrl_offset_binary,
  input  dac_pkg::dma_word_t samples_i,
  input  dac_pkg::dma_word_t samples_q,
  input  logic               samples_valid,
  output dac_pkg::out_word_t dac_data_out,
  output logic               dac_data_valid,
  output logic               dac_frame_out
);

  import dac_pkg::*;

  sample_t   fmt_mask;
  out_word_t word;

  // offset binary flips the msb only
  assign fmt_mask = {ctrl_offset_binary, {(SAMPLE_WIDTH-1){1'b0}}};

  // i0 in the low bits, then q0, i1, q1 ...
  always_comb begin
    for (int k = 0; k < SAMPLES_PER_CYCLE; k++) begin
      word[(2*k)*SAMPLE_WIDTH +: SAMPLE_WIDTH] =
        samples_i[k*SAMPLE_WIDTH +: SAMPLE_WIDTH] ^ fmt_mask;
      word[(2*k+1)*SAMPLE_WIDTH +: SAMPLE_WIDTH] =
        samples_q[k*SAMPLE_WIDTH +: SAMPLE_WIDTH] ^ fmt_mask;
    end
  end

  always_ff @(posedge dac_div_clk) begin
    if (reset) begin
      dac_data_out   <= '0;
      dac_data_valid <= 1'b0;
      dac_frame_out  <= 1'b0;
    end else begin
      dac_data_out   <= samples_valid ? word : '0;
      dac_data_valid <= samples_valid;
      // first valid word after a gap
      dac_frame_out  <= samples_valid & ~dac_data_valid;
    end
  end

  frame_in_valid: assert property (
    @(posedge dac_div_clk) disable iff (reset)
    dac_frame_out |-> dac_data_valid
  );

endmodule

// File: design/dac_pkg.sv
// ******************************
// dac transmit core definitions
// widths, register map, source codes
// ******************************

package dac_pkg;

  // ******************************
  // widths
  // ******************************

  localparam int SAMPLE_WIDTH      = 16;
  localparam int SAMPLES_PER_CYCLE = 4;
  localparam int DMA_WIDTH         = SAMPLE_WIDTH * SAMPLES_PER_CYCLE;
  localparam int OUT_WIDTH         = 2 * DMA_WIDTH;
  localparam int UP_ADDR_WIDTH     = 14;
  localparam int UP_DATA_WIDTH     = 32;

  typedef logic [SAMPLE_WIDTH-1:0]  sample_t;
  typedef logic [DMA_WIDTH-1:0]     dma_word_t;
  typedef logic [OUT_WIDTH-1:0]     out_word_t;
  typedef logic [UP_ADDR_WIDTH-1:0] up_addr_t;
  typedef logic [UP_DATA_WIDTH-1:0] up_data_t;
  typedef logic [1:0]               src_sel_t;

  // sample sources per channel
  localparam src_sel_t SRC_DMA     = 2'd0;
  localparam src_sel_t SRC_RAMP    = 2'd1;
  localparam src_sel_t SRC_PATTERN = 2'd2;
  localparam src_sel_t SRC_ZERO    = 2'd3;

  localparam up_data_t DAC_VERSION = 32'h0001_0100;

  // ******************************
  // register word addresses
  // ******************************

  localparam up_addr_t REG_VERSION     = 14'd0;
  // bit 0 enable, bit 1 sync mode, bit 2 offset binary
  localparam up_addr_t REG_CONTROL     = 14'd1;
  // bit 0 underflow, bit 1 overflow (w1c), bit 2 running
  localparam up_addr_t REG_STATUS      = 14'd2;
  localparam up_addr_t REG_CH0_SOURCE  = 14'd3;
  localparam up_addr_t REG_CH0_INCR    = 14'd4;
  localparam up_addr_t REG_CH0_PATTERN = 14'd5;
  localparam up_addr_t REG_CH1_SOURCE  = 14'd6;
  localparam up_addr_t REG_CH1_INCR    = 14'd7;
  localparam up_addr_t REG_CH1_PATTERN = 14'd8;

  // run control states
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_WAIT_SYNC,
    ST_RUN
  } run_state_t;

endpackage

// File: design/dac_ramp_gen.sv
// ******************************
// sawtooth ramp generator
// four consecutive samples per cycle
// ******************************

`timescale 1ns/1ps

module dac_ramp_gen (
  input  logic               dac_div_clk,
  input  logic               reset,
  input  logic               run,
  input  dac_pkg::sample_t   incr,
  output dac_pkg::dma_word_t ramp_data
);

  import dac_pkg::*;

  sample_t phase;
  sample_t step;

  // phase advances by one whole word of samples
  assign step = sample_t'(SAMPLES_PER_CYCLE) * incr;

  always_comb begin
    for (int k = 0; k < SAMPLES_PER_CYCLE; k++) begin
      ramp_data[k*SAMPLE_WIDTH +: SAMPLE_WIDTH] = phase + sample_t'(k) * incr;
    end
  end

  // held at zero while stopped, so every run starts at 0
  always_ff @(posedge dac_div_clk) begin
    if (reset) begin
      phase <= '0;
    end else if (run) begin
      phase <= phase + step;
    end else begin
      phase <= '0;
    end
  end

endmodule

// File: design/dac_regmap.sv
// ******************************
// dac register map on the up bus
// control, channel setup, sticky status
// ******************************

`timescale 1ns/1ps

module dac_regmap (
  input  logic              dac_div_clk,
  input  logic              reset,
  input  logic              up_wreq,
  input  dac_pkg::up_addr_t up_waddr,
  input  dac_pkg::up_data_t up_wdata,
  output logic              up_wack,
  input  logic              up_rreq,
  input  dac_pkg::up_addr_t up_raddr,
  output dac_pkg::up_data_t up_rdata,
  output logic              up_rack,
  input  logic              dac_running,
  input  logic              dac_dunf,
  input  logic              dac_dovf,
  output logic              ctrl_enable,
  output logic              ctrl_sync_mode,
  output logic              ctrl_offset_binary,
  output dac_pkg::src_sel_t ch0_source,
  output dac_pkg::src_sel_t ch1_source,
  output dac_pkg::sample_t  ch0_incr,
  output dac_pkg::sample_t  ch1_incr,
  output dac_pkg::sample_t  ch0_pattern,
  output dac_pkg::sample_t  ch1_pattern
);

  import dac_pkg::*;

  logic     unf_sticky;
  logic     ovf_sticky;
  logic     wr_status;
  up_data_t rd_mux;

  assign wr_status = up_wreq && (up_waddr == REG_STATUS);

  // ******************************
  // write decode
  // ******************************

  always_ff @(posedge dac_div_clk) begin
    if (reset) begin
      up_wack            <= 1'b0;
      ctrl_enable        <= 1'b0;
      ctrl_sync_mode     <= 1'b0;
      ctrl_offset_binary <= 1'b0;
      ch0_source         <= SRC_DMA;
      ch1_source         <= SRC_DMA;
      ch0_incr           <= '0;
      ch1_incr           <= '0;
      ch0_pattern        <= '0;
      ch1_pattern        <= '0;
    end else begin
      up_wack <= up_wreq;
      if (up_wreq) begin
        case (up_waddr)
          REG_CONTROL: begin
            ctrl_enable        <= up_wdata[0];
            ctrl_sync_mode     <= up_wdata[1];
            ctrl_offset_binary <= up_wdata[2];
          end
          REG_CH0_SOURCE:  ch0_source  <= up_wdata[1:0];
          REG_CH0_INCR:    ch0_incr    <= up_wdata[SAMPLE_WIDTH-1:0];
          REG_CH0_PATTERN: ch0_pattern <= up_wdata[SAMPLE_WIDTH-1:0];
          REG_CH1_SOURCE:  ch1_source  <= up_wdata[1:0];
          REG_CH1_INCR:    ch1_incr    <= up_wdata[SAMPLE_WIDTH-1:0];
          REG_CH1_PATTERN: ch1_pattern <= up_wdata[SAMPLE_WIDTH-1:0];
          default: ;
        endcase
      end
    end
  end

  // sticky status, a new event beats a clear on the same edge
  always_ff @(posedge dac_div_clk) begin
    if (reset) begin
      unf_sticky <= 1'b0;
      ovf_sticky <= 1'b0;
    end else begin
      unf_sticky <= dac_dunf | (unf_sticky & ~(wr_status & up_wdata[0]));
      ovf_sticky <= dac_dovf | (ovf_sticky & ~(wr_status & up_wdata[1]));
    end
  end

  // ******************************
  // read path
  // ******************************

  always_comb begin
    rd_mux = '0;
    case (up_raddr)
      REG_VERSION:     rd_mux = DAC_VERSION;
      REG_CONTROL:     rd_mux[2:0] = {ctrl_offset_binary, ctrl_sync_mode, ctrl_enable};
      REG_STATUS:      rd_mux[2:0] = {dac_running, ovf_sticky, unf_sticky};
      REG_CH0_SOURCE:  rd_mux[1:0] = ch0_source;
      REG_CH0_INCR:    rd_mux[SAMPLE_WIDTH-1:0] = ch0_incr;
      REG_CH0_PATTERN: rd_mux[SAMPLE_WIDTH-1:0] = ch0_pattern;
      REG_CH1_SOURCE:  rd_mux[1:0] = ch1_source;
      REG_CH1_INCR:    rd_mux[SAMPLE_WIDTH-1:0] = ch1_incr;
      REG_CH1_PATTERN: rd_mux[SAMPLE_WIDTH-1:0] = ch1_pattern;
      default:         rd_mux = '0;
    endcase
  end

  always_ff @(posedge dac_div_clk) begin
    if (reset) begin
      up_rack  <= 1'b0;
      up_rdata <= '0;
    end else begin
      up_rack  <= up_rreq;
      up_rdata <= up_rreq ? rd_mux : '0;
    end
  end

  // every write ack answers a request one cycle earlier
  wack_follows_wreq: assert property (
    @(posedge dac_div_clk) disable iff (reset)
    up_wack |-> $past(up_wreq)
  );

endmodule

// File: design/dac_top.sv
// ******************************
// dac transmit core top level
// ******************************

`timescale 1ns/1ps

module dac_top (
  input  logic               dac_div_clk,
  input  logic               reset,

  // up bus
  input  logic               up_wreq,
  input  dac_pkg::up_addr_t  up_waddr,
  input  dac_pkg::up_data_t  up_wdata,
  output logic               up_wack,
  input  logic               up_rreq,
  input  dac_pkg::up_addr_t  up_raddr,
  output dac_pkg::up_data_t  up_rdata,
  output logic               up_rack,

  // master/slave
  input  logic               dac_sync_in,
  output logic               dac_sync_out,

  // dma
  output logic               dac_valid_0,
  output logic               dac_enable_0,
  input  dac_pkg::dma_word_t dac_ddata_0,
  output logic               dac_valid_1,
  output logic               dac_enable_1,
  input  dac_pkg::dma_word_t dac_ddata_1,
  input  logic               dac_dunf,
  input  logic               dac_dovf,

  // converter side
  output dac_pkg::out_word_t dac_data_out,
  output logic               dac_data_valid,
  output logic               dac_frame_out
);

  import dac_pkg::*;

  logic      ctrl_enable;
  logic      ctrl_sync_mode;
  logic      ctrl_offset_binary;
  src_sel_t  ch0_source;
  src_sel_t  ch1_source;
  sample_t   ch0_incr;
  sample_t   ch1_incr;
  sample_t   ch0_pattern;
  sample_t   ch1_pattern;
  logic      dac_running;
  dma_word_t samples_i;
  dma_word_t samples_q;
  logic      samples_valid;

  dac_regmap i_regmap (
    .dac_div_clk        (dac_div_clk),
    .reset              (reset),
    .up_wreq            (up_wreq),
    .up_waddr           (up_waddr),
    .up_wdata           (up_wdata),
    .up_wack            (up_wack),
    .up_rreq            (up_rreq),
    .up_raddr           (up_raddr),
    .up_rdata           (up_rdata),
    .up_rack            (up_rack),
    .dac_running        (dac_running),
    .dac_dunf           (dac_dunf),
    .dac_dovf           (dac_dovf),
    .ctrl_enable        (ctrl_enable),
    .ctrl_sync_mode     (ctrl_sync_mode),
    .ctrl_offset_binary (ctrl_offset_binary),
    .ch0_source         (ch0_source),
    .ch1_source         (ch1_source),
    .ch0_incr           (ch0_incr),
    .ch1_incr           (ch1_incr),
    .ch0_pattern        (ch0_pattern),
    .ch1_pattern        (ch1_pattern)
  );

  dac_core i_core (
    .dac_div_clk    (dac_div_clk),
    .reset          (reset),
    .ctrl_enable    (ctrl_enable),
    .ctrl_sync_mode (ctrl_sync_mode),
    .ch0_source     (ch0_source),
    .ch1_source     (ch1_source),
    .ch0_incr       (ch0_incr),
    .ch1_incr       (ch1_incr),
    .ch0_pattern    (ch0_pattern),
    .ch1_pattern    (ch1_pattern),
    .dac_sync_in    (dac_sync_in),
    .dac_sync_out   (dac_sync_out),
    .dac_valid_0    (dac_valid_0),
    .dac_valid_1    (dac_valid_1),
    .dac_enable_0   (dac_enable_0),
    .dac_enable_1   (dac_enable_1),
    .dac_ddata_0    (dac_ddata_0),
    .dac_ddata_1    (dac_ddata_1),
    .dac_running    (dac_running),
    .samples_i      (samples_i),
    .samples_q      (samples_q),
    .samples_valid  (samples_valid)
  );

  dac_output_if i_output_if (
    .dac_div_clk        (dac_div_clk),
    .reset              (reset),
    .ctrl_offset_binary (ctrl_offset_binary),
    .samples_i          (samples_i),
    .samples_q          (samples_q),
    .samples_valid      (samples_valid),
    .dac_data_out       (dac_data_out),
    .dac_data_valid     (dac_data_valid),
    .dac_frame_out      (dac_frame_out)
  );

endmodule

// File: run_sim.sh
#!/bin/sh
# build and run the dac testbench with verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir sim.log

verilator --binary --timing --assert -j 0 -f sim.f --top-module tb_dac_top -o tb_dac_top

./obj_dir/tb_dac_top | tee sim.log || true

if grep -q "=== FAIL ===" sim.log; then
  echo "simulation failed, see sim.log"
  exit 1
fi
if ! grep -q "=== PASS ===" sim.log; then
  echo "simulation ended without a result, see sim.log"
  exit 1
fi
echo "simulation passed"

// File: sim.f
design/dac_pkg.sv
design/dac_regmap.sv
design/dac_ramp_gen.sv
design/dac_channel.sv
design/dac_core.sv
design/dac_output_if.sv
design/dac_top.sv
verif/tb_dac_top.sv

// File: verif/dac_test_input.txt
// columns: op a b c (hex). op 1 write a<=b, 2 read a expect c, 3 write a<=b then expect c,
// 4 run control a with sources b (ch0 1:0, ch1 5:4) for c cycles, 5 sync pulse then c cycles,
// 6 dunf/dovf pulse a then c cycles, 7 end of test a, f end of file
2 0000 00000000 00010100 // version
3 0001 00000006 00000006 // control without enable
3 0003 ffffffff 00000003
3 0004 0000abcd 0000abcd
3 0005 12345678 00005678
3 0006 00000001 00000001
3 0007 00001111 00001111
3 0008 0000fedc 0000fedc
2 0031 00000000 00000000 // unmapped
1 0001 00000000 00000000
7 0001 00000000 00000000
4 0001 00000000 00000010 // dma on both channels
1 0001 00000000 00000000
7 0002 00000000 00000000
1 0005 00001234 00000000
1 0008 00007e01 00000000
4 0005 00000022 00000008 // pattern, offset binary
1 0001 00000000 00000000
4 0001 00000023 00000008 // ch0 zero, ch1 pattern
1 0001 00000000 00000000
7 0003 00000000 00000000
1 0004 00000003 00000000
1 0007 00001001 00000000
4 0001 00000011 0000000c // ramp
1 0001 00000000 00000000
4 0001 00000011 00000006 // ramp restarts at 0
1 0001 00000000 00000000
7 0004 00000000 00000000
4 0003 00000022 00000006 // sync mode, waits for sync_in
5 0000 00000000 00000008
1 0001 00000000 00000000
7 0005 00000000 00000000
2 0002 00000000 00000000
6 0001 00000000 00000001 // underflow
2 0002 00000000 00000001
6 0002 00000000 00000001 // overflow
2 0002 00000000 00000003
1 0002 00000001 00000000
2 0002 00000000 00000002
1 0002 00000002 00000000
2 0002 00000000 00000000
4 0001 00000000 00000004
2 0002 00000000 00000004 // running
1 0001 00000000 00000000
2 0002 00000000 00000000
7 0006 00000000 00000000
f 0000 00000000 00000000

// File: verif/tb_dac_top.sv
// ******************************
// dac transmit core testbench
// command file stimulus, cycle model checks
// ******************************

`timescale 1ns/1ps

module tb_dac_top;

  import dac_pkg::*;

  localparam int          MEM_WORDS = 512;
  localparam logic [31:0] OP_WRITE  = 32'h1;
  localparam logic [31:0] OP_READ   = 32'h2;
  localparam logic [31:0] OP_CHECK  = 32'h3;
  localparam logic [31:0] OP_RUN    = 32'h4;
  localparam logic [31:0] OP_SYNC   = 32'h5;
  localparam logic [31:0] OP_FLAG   = 32'h6;
  localparam logic [31:0] OP_END    = 32'h7;
  localparam logic [31:0] OP_EOF    = 32'hf;

  logic      dac_div_clk;
  logic      reset;
  logic      up_wreq;
  up_addr_t  up_waddr;
  up_data_t  up_wdata;
  logic      up_wack;
  logic      up_rreq;
  up_addr_t  up_raddr;
  up_data_t  up_rdata;
  logic      up_rack;
  logic      dac_sync_in;
  logic      dac_sync_out;
  logic      dac_valid_0;
  logic      dac_enable_0;
  dma_word_t dac_ddata_0;
  logic      dac_valid_1;
  logic      dac_enable_1;
  dma_word_t dac_ddata_1;
  logic      dac_dunf;
  logic      dac_dovf;
  out_word_t dac_data_out;
  logic      dac_data_valid;
  logic      dac_frame_out;

  // values for the next falling edge
  logic     nxt_wreq;
  up_addr_t nxt_waddr;
  up_data_t nxt_wdata;
  logic     nxt_rreq;
  up_addr_t nxt_raddr;
  logic     nxt_sync;
  logic     nxt_dunf;
  logic     nxt_dovf;

  // ******************************
  // reference model state
  // ******************************

  logic       m_en;
  logic       m_en_d;
  logic       m_sync;
  logic       m_ob;
  run_state_t m_state;
  src_sel_t   m_src0;
  src_sel_t   m_src1;
  sample_t    m_incr0;
  sample_t    m_incr1;
  sample_t    m_pat0;
  sample_t    m_pat1;
  logic       m_wack;
  logic       m_rack;
  int         ramp_n;
  logic       st1_valid;
  dma_word_t  st1_i;
  dma_word_t  st1_q;
  logic       st2_valid;
  logic       st2_frame;
  out_word_t  st2_word;

  logic [31:0] cmd_mem [0:MEM_WORDS-1];
  logic [31:0] lfsr;
  int          errors = 0;
  int          test_errors = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  int          cycles = 0;
  int          cycle_limit = 200;

  dac_top i_dac_top (
    .dac_div_clk    (dac_div_clk),
    .reset          (reset),
    .up_wreq        (up_wreq),
    .up_waddr       (up_waddr),
    .up_wdata       (up_wdata),
    .up_wack        (up_wack),
    .up_rreq        (up_rreq),
    .up_raddr       (up_raddr),
    .up_rdata       (up_rdata),
    .up_rack        (up_rack),
    .dac_sync_in    (dac_sync_in),
    .dac_sync_out   (dac_sync_out),
    .dac_valid_0    (dac_valid_0),
    .dac_enable_0   (dac_enable_0),
    .dac_ddata_0    (dac_ddata_0),
    .dac_valid_1    (dac_valid_1),
    .dac_enable_1   (dac_enable_1),
    .dac_ddata_1    (dac_ddata_1),
    .dac_dunf       (dac_dunf),
    .dac_dovf       (dac_dovf),
    .dac_data_out   (dac_data_out),
    .dac_data_valid (dac_data_valid),
    .dac_frame_out  (dac_frame_out)
  );

  always #10 dac_div_clk = ~dac_div_clk;

  always @(posedge dac_div_clk) begin
    cycles++;
    if (cycles > cycle_limit) begin
      $display("timeout: the command file did not finish within %0d cycles", cycle_limit);
      $display("=== FAIL ===");
      $finish;
    end
  end

  // taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic random_word(output dma_word_t w);
    for (int b = 0; b < DMA_WIDTH; b++) begin
      lfsr = lfsr_next(lfsr);
      w[b] = lfsr[0];
    end
  endtask

  // expected channel word for word n of the current run
  function automatic dma_word_t source_word(input src_sel_t src, input dma_word_t dma,
                                            input sample_t incr, input sample_t pat,
                                            input int n);
    dma_word_t w;
    w = '0;
    for (int k = 0; k < SAMPLES_PER_CYCLE; k++) begin
      case (src)
        SRC_DMA:     w[k*SAMPLE_WIDTH +: SAMPLE_WIDTH] = dma[k*SAMPLE_WIDTH +: SAMPLE_WIDTH];
        SRC_RAMP:    w[k*SAMPLE_WIDTH +: SAMPLE_WIDTH] = sample_t'((4 * n + k) * int'(incr));
        SRC_PATTERN: w[k*SAMPLE_WIDTH +: SAMPLE_WIDTH] = pat;
        default:     w[k*SAMPLE_WIDTH +: SAMPLE_WIDTH] = '0;
      endcase
    end
    return w;
  endfunction

  // i0 lowest, then q0, i1, q1 and so on
  function automatic out_word_t interleave(input dma_word_t i_word, input dma_word_t q_word,
                                           input logic ob);
    out_word_t w;
    sample_t   flip;
    flip = ob ? 16'h8000 : 16'h0000;
    for (int k = 0; k < SAMPLES_PER_CYCLE; k++) begin
      w[(2*k)*SAMPLE_WIDTH +: SAMPLE_WIDTH]   = i_word[k*SAMPLE_WIDTH +: SAMPLE_WIDTH] ^ flip;
      w[(2*k+1)*SAMPLE_WIDTH +: SAMPLE_WIDTH] = q_word[k*SAMPLE_WIDTH +: SAMPLE_WIDTH] ^ flip;
    end
    return w;
  endfunction

  task automatic report_error(input string msg);
    $display("[ERROR] t=%0t %s", $time, msg);
    errors++;
    test_errors++;
  endtask

  task automatic note_failure(input string msg);
    $display("%s", msg);
    errors++;
    test_errors++;
  endtask

  task automatic check_outputs();
    logic exp_valid;
    exp_valid = (m_state == ST_RUN) && m_en;
    if (dac_valid_0 !== exp_valid || dac_valid_1 !== exp_valid) begin
      report_error($sformatf("dma valid %b/%b, expected %b", dac_valid_0, dac_valid_1,
                             exp_valid));
    end
    if (dac_enable_0 !== (m_en && (m_src0 == SRC_DMA))) begin
      report_error($sformatf("dac_enable_0 is %b", dac_enable_0));
    end
    if (dac_enable_1 !== (m_en && (m_src1 == SRC_DMA))) begin
      report_error($sformatf("dac_enable_1 is %b", dac_enable_1));
    end
    if (dac_sync_out !== (m_en && !m_en_d)) begin
      report_error($sformatf("dac_sync_out is %b", dac_sync_out));
    end
    if (up_wack !== m_wack || up_rack !== m_rack) begin
      report_error($sformatf("acks w/r %b/%b, expected %b/%b", up_wack, up_rack,
                             m_wack, m_rack));
    end
    if (dac_data_valid !== st2_valid || dac_frame_out !== st2_frame) begin
      report_error($sformatf("valid/frame %b/%b, expected %b/%b", dac_data_valid,
                             dac_frame_out, st2_valid, st2_frame));
    end
    if (dac_data_out !== st2_word) begin
      report_error($sformatf("output word %h, expected %h", dac_data_out, st2_word));
    end
  endtask

  // ******************************
  // one clock cycle
  // ******************************

  task automatic cycle();
    dma_word_t data_i;
    dma_word_t data_q;
    logic      cur_valid;
    @(negedge dac_div_clk);
    check_outputs();
    random_word(data_i);
    random_word(data_q);
    up_wreq     = nxt_wreq;
    up_waddr    = nxt_waddr;
    up_wdata    = nxt_wdata;
    up_rreq     = nxt_rreq;
    up_raddr    = nxt_raddr;
    dac_sync_in = nxt_sync;
    dac_dunf    = nxt_dunf;
    dac_dovf    = nxt_dovf;
    dac_ddata_0 = data_i;
    dac_ddata_1 = data_q;
    // advance the model across the coming rising edge
    cur_valid = (m_state == ST_RUN) && m_en;
    st2_frame = st1_valid && !st2_valid;
    st2_valid = st1_valid;
    st2_word  = st1_valid ? interleave(st1_i, st1_q, m_ob) : '0;
    st1_valid = cur_valid;
    st1_i     = cur_valid ? source_word(m_src0, data_i, m_incr0, m_pat0, ramp_n) : '0;
    st1_q     = cur_valid ? source_word(m_src1, data_q, m_incr1, m_pat1, ramp_n) : '0;
    ramp_n    = cur_valid ? ramp_n + 1 : 0;
    if (!m_en) begin
      m_state = ST_IDLE;
    end else if (m_state == ST_IDLE && !m_en_d) begin
      m_state = m_sync ? ST_WAIT_SYNC : ST_RUN;
    end else if (m_state == ST_WAIT_SYNC && nxt_sync) begin
      m_state = ST_RUN;
    end
    m_en_d = m_en;
    m_wack = nxt_wreq;
    m_rack = nxt_rreq;
    if (nxt_wreq) begin
      case (nxt_waddr)
        REG_CONTROL: begin
          m_en   = nxt_wdata[0];
          m_sync = nxt_wdata[1];
          m_ob   = nxt_wdata[2];
        end
        REG_CH0_SOURCE:  m_src0  = nxt_wdata[1:0];
        REG_CH0_INCR:    m_incr0 = nxt_wdata[15:0];
        REG_CH0_PATTERN: m_pat0  = nxt_wdata[15:0];
        REG_CH1_SOURCE:  m_src1  = nxt_wdata[1:0];
        REG_CH1_INCR:    m_incr1 = nxt_wdata[15:0];
        REG_CH1_PATTERN: m_pat1  = nxt_wdata[15:0];
        default: ;
      endcase
    end
    nxt_wreq = 1'b0;
    nxt_rreq = 1'b0;
    nxt_sync = 1'b0;
    nxt_dunf = 1'b0;
    nxt_dovf = 1'b0;
  endtask

  task automatic reg_write(input up_addr_t addr, input up_data_t data);
    int waited;
    nxt_wreq  = 1'b1;
    nxt_waddr = addr;
    nxt_wdata = data;
    cycle();
    waited = 0;
    do begin
      cycle();
      waited++;
    end while (!up_wack && waited < 4);
    if (!up_wack) begin
      note_failure($sformatf("write to register %0d was never acknowledged", addr));
    end
  endtask

  task automatic reg_read(input up_addr_t addr, input up_data_t expected);
    int waited;
    nxt_rreq  = 1'b1;
    nxt_raddr = addr;
    cycle();
    waited = 0;
    do begin
      cycle();
      waited++;
    end while (!up_rack && waited < 4);
    if (!up_rack) begin
      note_failure($sformatf("read of register %0d was never acknowledged", addr));
    end else if (up_rdata !== expected) begin
      report_error($sformatf("register %0d read %h, expected %h", addr, up_rdata, expected));
    end
  endtask

  task automatic finish_test(input logic [31:0] num);
    repeat (4) cycle();
    tests_run++;
    if (test_errors == 0) begin
      $display("test %0d: passed", num);
    end else begin
      tests_failed++;
      $display("test %0d: failed with %0d errors", num, test_errors);
    end
    test_errors = 0;
  endtask

  // ******************************
  // command file sequencer
  // ******************************

  initial begin
    logic [31:0] op;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    int          n_records;
    dac_div_clk = 1'b0;
    reset       = 1'b1;
    up_wreq     = 1'b0;
    up_waddr    = '0;
    up_wdata    = '0;
    up_rreq     = 1'b0;
    up_raddr    = '0;
    dac_sync_in = 1'b0;
    dac_dunf    = 1'b0;
    dac_dovf    = 1'b0;
    dac_ddata_0 = '0;
    dac_ddata_1 = '0;
    nxt_wreq    = 1'b0;
    nxt_waddr   = '0;
    nxt_wdata   = '0;
    nxt_rreq    = 1'b0;
    nxt_raddr   = '0;
    nxt_sync    = 1'b0;
    nxt_dunf    = 1'b0;
    nxt_dovf    = 1'b0;
    lfsr        = 32'hbcc6_5c72;
    {m_en, m_en_d, m_sync, m_ob, m_wack, m_rack} = '0;
    m_state   = ST_IDLE;
    m_src0    = SRC_DMA;
    m_src1    = SRC_DMA;
    m_incr0   = '0;
    m_incr1   = '0;
    m_pat0    = '0;
    m_pat1    = '0;
    ramp_n    = 0;
    st1_valid = 1'b0;
    st1_i     = '0;
    st1_q     = '0;
    st2_valid = 1'b0;
    st2_frame = 1'b0;
    st2_word  = '0;
    for (int i = 0; i < MEM_WORDS; i++) begin
      cmd_mem[i] = '0;
    end
    $readmemh("verif/dac_test_input.txt", cmd_mem);
    n_records = 0;
    while (4 * n_records < MEM_WORDS && cmd_mem[4*n_records] != OP_EOF) begin
      n_records++;
    end
    cycle_limit = 64 * n_records + 200;

    repeat (8) @(posedge dac_div_clk);
    @(negedge dac_div_clk);
    reset = 1'b0;

    for (int r = 0; r < n_records; r++) begin
      op = cmd_mem[4*r];
      a  = cmd_mem[4*r+1];
      b  = cmd_mem[4*r+2];
      c  = cmd_mem[4*r+3];
      case (op)
        OP_WRITE: reg_write(up_addr_t'(a), b);
        OP_READ:  reg_read(up_addr_t'(a), c);
        OP_CHECK: begin
          reg_write(up_addr_t'(a), b);
          reg_read(up_addr_t'(a), c);
        end
        OP_RUN: begin
          reg_write(REG_CH0_SOURCE, b & 32'h3);
          reg_write(REG_CH1_SOURCE, (b >> 4) & 32'h3);
          reg_write(REG_CONTROL, a);
          repeat (c) cycle();
        end
        OP_SYNC: begin
          nxt_sync = 1'b1;
          repeat (c) cycle();
        end
        OP_FLAG: begin
          nxt_dunf = a[0];
          nxt_dovf = a[1];
          repeat (c) cycle();
        end
        OP_END:   finish_test(a);
        default:  note_failure($sformatf("unknown command %h in record %0d", op, r));
      endcase
    end

    repeat (4) cycle();
    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule
